// File: source/hex_command_parser.sv
`timescale 1ns/1ps
`default_nettype none

module hex_command_parser (
  input  wire logic                               clk,
  input  wire logic                               rst,
  input  wire logic [la_host_pkg::DATA_W-1:0]     rd_data,
  input  wire logic                               empty,
  input  wire logic                               response_done,
  output logic                                    pop,
  output logic                                    setting_write,
  output la_host_pkg::setting_sel_t               setting_sel,
  output logic      [la_host_pkg::SETTING_W-1:0]  setting_value,
  output logic                                    settings_hold,
  output logic                                    enable_write,
  output logic                                    enable_value,
  output logic                                    la_reset,
  output logic                                    response_start,
  output logic      [la_host_pkg::DATA_W-1:0]     response_status,
  output logic                                    with_arg
);

  la_host_pkg::parse_state_t                  state;
  la_host_pkg::la_opcode_t                    opcode;
  logic                                       byte_valid;
  logic                                       is_line_feed;
  logic [3:0]                                 nibble;
  logic [$clog2(la_host_pkg::HEX_DIGITS)-1:0] digit_count;

  assign opcode       = la_host_pkg::la_opcode_t'(rd_data);
  assign is_line_feed = (rd_data == la_host_pkg::LINE_FEED);
  // uppercase hex only, 'A' has 1 in its low nibble
  assign nibble       = (rd_data >= 8'h41) ? rd_data[3:0] + 4'd9 : rd_data[3:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= la_host_pkg::ps_idle;
      pop            <= 1'b0;
      byte_valid     <= 1'b0;
      setting_write  <= 1'b0;
      settings_hold  <= 1'b0;
      enable_write   <= 1'b0;
      la_reset       <= 1'b0;
      response_start <= 1'b0;
      digit_count    <= '0;
    end else begin
      setting_write  <= 1'b0;
      settings_hold  <= 1'b0;
      enable_write   <= 1'b0;
      la_reset       <= 1'b0;
      response_start <= 1'b0;

      // one byte in flight, nothing taken while a response goes out
      pop        <= !empty && !pop && !byte_valid &&
                    (state != la_host_pkg::ps_wait_response);
      byte_valid <= pop;

      if (state == la_host_pkg::ps_wait_response) begin
        if (response_done) begin
          state <= la_host_pkg::ps_idle;
        end
      end else if (byte_valid) begin
        if (is_line_feed && (state != la_host_pkg::ps_line_feed)) begin
          // early line feed drops the line silently
          state <= la_host_pkg::ps_idle;
        end else begin
          case (state)
            la_host_pkg::ps_idle: begin
              if (rd_data == la_host_pkg::START_ID) begin
                state <= la_host_pkg::ps_command;
              end
            end
            la_host_pkg::ps_command: begin
              response_status <= la_host_pkg::RESPONSE_SUCCESS;
              with_arg        <= 1'b0;
              state           <= la_host_pkg::ps_line_feed;
              case (opcode)
                la_host_pkg::op_ping: begin
                  // answer only
                end
                la_host_pkg::op_reset: begin
                  la_reset <= 1'b1;
                end
                la_host_pkg::op_set_enable: begin
                  state <= la_host_pkg::ps_enable_value;
                end
                la_host_pkg::op_get_enable: begin
                  with_arg <= 1'b1;
                end
                la_host_pkg::op_write_trigger,
                la_host_pkg::op_write_mask,
                la_host_pkg::op_write_trigger_after,
                la_host_pkg::op_write_trigger_edge,
                la_host_pkg::op_write_both_edges,
                la_host_pkg::op_write_repeat_count: begin
                  // capture stops while settings change
                  settings_hold <= 1'b1;
                  setting_sel   <= la_host_pkg::setting_sel_t'(
                                     3'(rd_data - la_host_pkg::op_write_trigger));
                  digit_count   <= '0;
                  state         <= la_host_pkg::ps_hex_value;
                end
                default: begin
                  response_status <= la_host_pkg::RESPONSE_FAIL;
                end
              endcase
            end
            la_host_pkg::ps_hex_value: begin
              // most significant digit first
              setting_value <= {setting_value[la_host_pkg::SETTING_W-5:0], nibble};
              digit_count   <= digit_count + 1'b1;
              if (digit_count == la_host_pkg::HEX_DIGITS - 1) begin
                setting_write <= 1'b1;
                state         <= la_host_pkg::ps_line_feed;
              end
            end
            la_host_pkg::ps_enable_value: begin
              if ((rd_data == la_host_pkg::HEX_0) ||
                  (rd_data == la_host_pkg::HEX_0 + 8'd1)) begin
                enable_write    <= 1'b1;
                enable_value    <= rd_data[0];
                response_status <= la_host_pkg::RESPONSE_SUCCESS;
              end else begin
                response_status <= la_host_pkg::RESPONSE_FAIL;
              end
              state <= la_host_pkg::ps_line_feed;
            end
            la_host_pkg::ps_line_feed: begin
              // anything but the line feed is skipped here
              if (is_line_feed) begin
                response_start <= 1'b1;
                state          <= la_host_pkg::ps_wait_response;
              end
            end
            default: begin
              state <= la_host_pkg::ps_idle;
            end
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/la_host_link.sv
`timescale 1ns/1ps
`default_nettype none

module la_host_link (
  input  wire logic                               clk,
  input  wire logic                               rst,
  input  wire logic                               rx_strobe,
  input  wire logic [la_host_pkg::DATA_W-1:0]     rx_data,
  input  wire logic                               tx_full,
  input  wire logic                               disable_capture,
  output logic                                    tx_strobe,
  output logic      [la_host_pkg::DATA_W-1:0]     tx_data,
  output logic                                    rx_overflow,
  output logic      [la_host_pkg::SETTING_W-1:0]  trigger,
  output logic      [la_host_pkg::SETTING_W-1:0]  trigger_mask,
  output logic      [la_host_pkg::SETTING_W-1:0]  trigger_after,
  output logic      [la_host_pkg::SETTING_W-1:0]  trigger_edge,
  output logic      [la_host_pkg::SETTING_W-1:0]  both_edges,
  output logic      [la_host_pkg::SETTING_W-1:0]  repeat_count,
  output logic                                    enable,
  output logic                                    set_strobe,
  output logic                                    la_reset
);

  // receive byte path
  logic                               fifo_pop;
  logic [la_host_pkg::DATA_W-1:0]     fifo_rd_data;
  logic                               fifo_empty;

  // settings path
  logic                               setting_write;
  la_host_pkg::setting_sel_t          setting_sel;
  logic [la_host_pkg::SETTING_W-1:0]  setting_value;
  logic                               settings_hold;
  logic                               enable_write;
  logic                               enable_value;

  // response path
  logic                               response_start;
  logic [la_host_pkg::DATA_W-1:0]     response_status;
  logic                               with_arg;
  logic                               response_done;

  rx_byte_fifo rx_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (rx_strobe),
    .push_data (rx_data),
    .pop       (fifo_pop),
    .rd_data   (fifo_rd_data),
    .empty     (fifo_empty),
    .overflow  (rx_overflow)
  );

  hex_command_parser parser (
    .clk             (clk),
    .rst             (rst),
    .rd_data         (fifo_rd_data),
    .empty           (fifo_empty),
    .response_done   (response_done),
    .pop             (fifo_pop),
    .setting_write   (setting_write),
    .setting_sel     (setting_sel),
    .setting_value   (setting_value),
    .settings_hold   (settings_hold),
    .enable_write    (enable_write),
    .enable_value    (enable_value),
    .la_reset        (la_reset),
    .response_start  (response_start),
    .response_status (response_status),
    .with_arg        (with_arg)
  );

  la_settings_regs settings (
    .clk             (clk),
    .rst             (rst),
    .setting_write   (setting_write),
    .setting_sel     (setting_sel),
    .setting_value   (setting_value),
    .settings_hold   (settings_hold),
    .enable_write    (enable_write),
    .enable_value    (enable_value),
    .disable_capture (disable_capture),
    .trigger         (trigger),
    .trigger_mask    (trigger_mask),
    .trigger_after   (trigger_after),
    .trigger_edge    (trigger_edge),
    .both_edges      (both_edges),
    .repeat_count    (repeat_count),
    .enable          (enable),
    .set_strobe      (set_strobe)
  );

  response_writer writer (
    .clk             (clk),
    .rst             (rst),
    .response_start  (response_start),
    .response_status (response_status),
    .with_arg        (with_arg),
    .enable          (enable),
    .tx_full         (tx_full),
    .tx_strobe       (tx_strobe),
    .tx_data         (tx_data),
    .response_done   (response_done)
  );

endmodule

`default_nettype wire

// File: source/la_host_pkg.sv
`default_nettype none

package la_host_pkg;

  localparam int DATA_W     = 8;
  localparam int SETTING_W  = 32;
  localparam int HEX_DIGITS = 8;
  localparam int FIFO_DEPTH = 16;

  // line framing and response bytes
  localparam logic [7:0] START_ID         = 8'h4C;
  localparam logic [7:0] RESPONSE_ID      = 8'h52;
  localparam logic [7:0] RESPONSE_SUCCESS = 8'h4F;
  localparam logic [7:0] RESPONSE_FAIL    = 8'h46;
  localparam logic [7:0] LINE_FEED        = 8'h0A;
  localparam logic [7:0] CARRIAGE_RETURN  = 8'h0D;
  localparam logic [7:0] HEX_0            = 8'h30;

  // command byte that follows the start id
  typedef enum logic [7:0] {
    op_ping                = 8'h30,
    op_reset               = 8'h31,
    op_set_enable          = 8'h32,
    op_get_enable          = 8'h33,
    op_write_trigger       = 8'h34,
    op_write_mask          = 8'h35,
    op_write_trigger_after = 8'h36,
    op_write_trigger_edge  = 8'h37,
    op_write_both_edges    = 8'h38,
    op_write_repeat_count  = 8'h39
  } la_opcode_t;

  // order follows the write opcodes
  typedef enum logic [2:0] {
    sel_trigger,
    sel_trigger_mask,
    sel_trigger_after,
    sel_trigger_edge,
    sel_both_edges,
    sel_repeat_count
  } setting_sel_t;

  typedef enum logic [2:0] {
    ps_idle,
    ps_command,
    ps_hex_value,
    ps_enable_value,
    ps_line_feed,
    ps_wait_response
  } parse_state_t;

  typedef enum logic [2:0] {
    ws_idle,
    ws_id,
    ws_status,
    ws_arg,
    ws_cr,
    ws_lf
  } write_state_t;

endpackage

`default_nettype wire

// File: source/la_settings_regs.sv
`timescale 1ns/1ps
`default_nettype none

module la_settings_regs (
  input  wire logic                               clk,
  input  wire logic                               rst,
  input  wire logic                               setting_write,
  input  wire la_host_pkg::setting_sel_t          setting_sel,
  input  wire logic [la_host_pkg::SETTING_W-1:0]  setting_value,
  input  wire logic                               settings_hold,
  input  wire logic                               enable_write,
  input  wire logic                               enable_value,
  input  wire logic                               disable_capture,
  output logic      [la_host_pkg::SETTING_W-1:0]  trigger,
  output logic      [la_host_pkg::SETTING_W-1:0]  trigger_mask,
  output logic      [la_host_pkg::SETTING_W-1:0]  trigger_after,
  output logic      [la_host_pkg::SETTING_W-1:0]  trigger_edge,
  output logic      [la_host_pkg::SETTING_W-1:0]  both_edges,
  output logic      [la_host_pkg::SETTING_W-1:0]  repeat_count,
  output logic                                    enable,
  output logic                                    set_strobe
);

  always_ff @(posedge clk) begin
    if (rst) begin
      trigger       <= '0;
      trigger_mask  <= '0;
      trigger_after <= '0;
      trigger_edge  <= '0;
      both_edges    <= '0;
      repeat_count  <= '0;
      set_strobe    <= 1'b0;
    end else begin
      // one strobe per completed write
      set_strobe <= setting_write;
      if (setting_write) begin
        case (setting_sel)
          la_host_pkg::sel_trigger:       trigger       <= setting_value;
          la_host_pkg::sel_trigger_mask:  trigger_mask  <= setting_value;
          la_host_pkg::sel_trigger_after: trigger_after <= setting_value;
          la_host_pkg::sel_trigger_edge:  trigger_edge  <= setting_value;
          la_host_pkg::sel_both_edges:    both_edges    <= setting_value;
          la_host_pkg::sel_repeat_count:  repeat_count  <= setting_value;
          default: begin
            trigger <= trigger;
          end
        endcase
      end
    end
  end

  // capture enable, the disable input wins over a host write
  always_ff @(posedge clk) begin
    if (rst) begin
      enable <= 1'b0;
    end else if (disable_capture || settings_hold) begin
      enable <= 1'b0;
    end else if (enable_write) begin
      enable <= enable_value;
    end
  end

endmodule

`default_nettype wire

// File: source/response_writer.sv
`timescale 1ns/1ps
`default_nettype none

module response_writer (
  input  wire logic                           clk,
  input  wire logic                           rst,
  input  wire logic                           response_start,
  input  wire logic [la_host_pkg::DATA_W-1:0] response_status,
  input  wire logic                           with_arg,
  input  wire logic                           enable,
  input  wire logic                           tx_full,
  output logic                                tx_strobe,
  output logic      [la_host_pkg::DATA_W-1:0] tx_data,
  output logic                                response_done
);

  la_host_pkg::write_state_t        state;
  logic [la_host_pkg::DATA_W-1:0]   byte_q;
  logic [la_host_pkg::DATA_W-1:0]   status_q;
  logic                             with_arg_q;

  // current byte is held in byte_q until the transmit side has room
  assign tx_strobe     = (state != la_host_pkg::ws_idle) && !tx_full;
  assign tx_data       = byte_q;
  assign response_done = (state == la_host_pkg::ws_lf) && !tx_full;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= la_host_pkg::ws_idle;
    end else begin
      case (state)
        la_host_pkg::ws_idle: begin
          if (response_start) begin
            state <= la_host_pkg::ws_id;
          end
        end
        la_host_pkg::ws_id: begin
          if (!tx_full) begin
            state <= la_host_pkg::ws_status;
          end
        end
        la_host_pkg::ws_status: begin
          if (!tx_full) begin
            state <= with_arg_q ? la_host_pkg::ws_arg : la_host_pkg::ws_cr;
          end
        end
        la_host_pkg::ws_arg: begin
          if (!tx_full) begin
            state <= la_host_pkg::ws_cr;
          end
        end
        la_host_pkg::ws_cr: begin
          if (!tx_full) begin
            state <= la_host_pkg::ws_lf;
          end
        end
        la_host_pkg::ws_lf: begin
          if (!tx_full) begin
            state <= la_host_pkg::ws_idle;
          end
        end
        default: begin
          state <= la_host_pkg::ws_idle;
        end
      endcase
    end
  end

  // next byte loads as the current one leaves
  always_ff @(posedge clk) begin
    if ((state == la_host_pkg::ws_idle) && response_start) begin
      status_q   <= response_status;
      with_arg_q <= with_arg;
      byte_q     <= la_host_pkg::RESPONSE_ID;
    end else if (tx_strobe) begin
      case (state)
        la_host_pkg::ws_id: begin
          byte_q <= status_q;
        end
        la_host_pkg::ws_status: begin
          // enable sampled here for the argument digit
          byte_q <= with_arg_q ?
                    la_host_pkg::HEX_0 + {{(la_host_pkg::DATA_W-1){1'b0}}, enable} :
                    la_host_pkg::CARRIAGE_RETURN;
        end
        la_host_pkg::ws_arg: begin
          byte_q <= la_host_pkg::CARRIAGE_RETURN;
        end
        la_host_pkg::ws_cr: begin
          byte_q <= la_host_pkg::LINE_FEED;
        end
        default: begin
          byte_q <= byte_q;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/rx_byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rx_byte_fifo (
  input  wire logic                             clk,
  input  wire logic                             rst,
  input  wire logic                             push,
  input  wire logic [la_host_pkg::DATA_W-1:0]   push_data,
  input  wire logic                             pop,
  output logic      [la_host_pkg::DATA_W-1:0]   rd_data,
  output logic                                  empty,
  output logic                                  overflow
);

  logic [la_host_pkg::DATA_W-1:0]           mem [la_host_pkg::FIFO_DEPTH];
  logic [$clog2(la_host_pkg::FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(la_host_pkg::FIFO_DEPTH)-1:0] rd_ptr;
  logic [$clog2(la_host_pkg::FIFO_DEPTH):0]   count;
  logic                                       full;
  logic                                       do_push;
  logic                                       do_pop;

  assign full    = (count == la_host_pkg::FIFO_DEPTH);
  assign empty   = (count == '0);
  // a push into a full buffer is dropped even when a pop comes with it
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // storage, read data lands one cycle after the pop
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
    if (do_pop) begin
      rd_data <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // sticky until reset
      if (push && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+tb
source/la_host_pkg.sv
source/rx_byte_fifo.sv
source/hex_command_parser.sv
source/la_settings_regs.sv
source/response_writer.sv
source/la_host_link.sv
tb/la_host_link_tb.sv

// File: tb/la_host_link_tests.svh
`ifndef LA_HOST_LINK_TESTS_SVH
`define LA_HOST_LINK_TESTS_SVH

// uppercase ascii hex digit
function automatic logic [7:0] hex_char(input logic [3:0] nibble);
  if (nibble < 4'd10) begin
    return 8'h30 + nibble;
  end
  return 8'h41 + nibble - 8'd10;
endfunction

// write line with the digits most significant first
function automatic string setting_line(input int sel, input logic [31:0] value);
  string line;
  int d;
  line = $sformatf("L%c", 8'h34 + sel);
  for (d = 7; d >= 0; d--) begin
    line = $sformatf("%s%c", line, hex_char(value[d*4 +: 4]));
  end
  return line;
endfunction

// one byte per cycle and a closing line feed
task automatic send_line(input string text);
  int i;
  for (i = 0; i < text.len(); i++) begin
    @(negedge clk);
    rx_strobe = 1'b1;
    rx_data   = text[i];
  end
  @(negedge clk);
  rx_strobe = 1'b1;
  rx_data   = la_host_pkg::LINE_FEED;
  @(negedge clk);
  rx_strobe = 1'b0;
endtask

task automatic expect_response(input logic [7:0] status, input bit has_arg,
                               input logic arg_bit);
  logic [7:0] expected [5];
  int n;
  int waited;
  int i;
  expected[0] = la_host_pkg::RESPONSE_ID;
  expected[1] = status;
  n = 2;
  if (has_arg) begin
    expected[n] = 8'h30 + arg_bit;
    n = n + 1;
  end
  expected[n]     = la_host_pkg::CARRIAGE_RETURN;
  expected[n + 1] = la_host_pkg::LINE_FEED;
  n = n + 2;
  waited = 0;
  while ((tx_q.size() < n) && (waited < RESPONSE_WAIT)) begin
    @(negedge clk);
    waited++;
  end
  if (tx_q.size() < n) begin
    stop_run("no complete response arrived within the wait limit");
  end
  // anything extra would follow right behind the line feed
  repeat (8) @(negedge clk);
  if (tx_q.size() != n) begin
    stop_run("the response had more bytes than expected");
  end
  for (i = 0; i < n; i++) begin
    check_byte("tx_data", expected[i], tx_q[i]);
  end
  tx_q.delete();
endtask

task automatic expect_silence(input int cycles);
  repeat (cycles) @(negedge clk);
  if (tx_q.size() != 0) begin
    stop_run("a response was sent for a line that should have been dropped");
  end
endtask

task automatic check_all_settings();
  check_setting("trigger", model_setting[0], trigger);
  check_setting("trigger_mask", model_setting[1], trigger_mask);
  check_setting("trigger_after", model_setting[2], trigger_after);
  check_setting("trigger_edge", model_setting[3], trigger_edge);
  check_setting("both_edges", model_setting[4], both_edges);
  check_setting("repeat_count", model_setting[5], repeat_count);
  check_bit("enable", model_enable, enable);
endtask

task automatic ping_test();
  send_line("L0");
  expect_response(la_host_pkg::RESPONSE_SUCCESS, 1'b0, 1'b0);
  check_all_settings();
endtask

task automatic write_settings_test();
  logic [31:0] values [6];
  logic [7:0]  strobes_before;
  int sel;
  for (sel = 0; sel < 6; sel++) begin
    values[sel] = $random(seed);
  end
  full_mode = FULL_RANDOM;
  for (sel = 0; sel < 6; sel++) begin
    // enable first so the clear by the write shows
    send_line("L21");
    expect_response(la_host_pkg::RESPONSE_SUCCESS, 1'b0, 1'b0);
    model_enable = 1'b1;
    check_bit("enable", model_enable, enable);
    strobes_before = set_strobe_count;
    send_line(setting_line(sel, values[sel]));
    expect_response(la_host_pkg::RESPONSE_SUCCESS, 1'b0, 1'b0);
    model_setting[sel] = values[sel];
    model_enable       = 1'b0;
    check_byte("set_strobe pulses", strobes_before + 8'd1, set_strobe_count);
    check_all_settings();
  end
  full_mode = FULL_LOW;
endtask

task automatic enable_test();
  send_line("L21");
  expect_response(la_host_pkg::RESPONSE_SUCCESS, 1'b0, 1'b0);
  model_enable = 1'b1;
  check_bit("enable", model_enable, enable);
  send_line("L3");
  expect_response(la_host_pkg::RESPONSE_SUCCESS, 1'b1, 1'b1);
  send_line("L20");
  expect_response(la_host_pkg::RESPONSE_SUCCESS, 1'b0, 1'b0);
  model_enable = 1'b0;
  check_bit("enable", model_enable, enable);
  send_line("L3");
  expect_response(la_host_pkg::RESPONSE_SUCCESS, 1'b1, 1'b0);
  send_line("L21");
  expect_response(la_host_pkg::RESPONSE_SUCCESS, 1'b0, 1'b0);
  model_enable = 1'b1;
  // bad enable digit fails and keeps the old value
  send_line("L2X");
  expect_response(la_host_pkg::RESPONSE_FAIL, 1'b0, 1'b0);
  check_bit("enable", model_enable, enable);
  @(negedge clk);
  disable_capture = 1'b1;
  repeat (2) @(negedge clk);
  model_enable = 1'b0;
  check_bit("enable", model_enable, enable);
  disable_capture = 1'b0;
endtask

task automatic reset_opcode_test();
  logic [7:0] resets_before;
  resets_before = la_reset_count;
  send_line("L1");
  expect_response(la_host_pkg::RESPONSE_SUCCESS, 1'b0, 1'b0);
  check_byte("la_reset pulses", resets_before + 8'd1, la_reset_count);
  send_line("LZ");
  expect_response(la_host_pkg::RESPONSE_FAIL, 1'b0, 1'b0);
  check_all_settings();
endtask

task automatic line_abort_test();
  logic [7:0] strobes_before;
  send_line("L21");
  expect_response(la_host_pkg::RESPONSE_SUCCESS, 1'b0, 1'b0);
  model_enable = 1'b1;
  check_bit("enable", model_enable, enable);
  strobes_before = set_strobe_count;
  send_line("L4AB");
  expect_silence(60);
  // the write opcode alone clears enable
  model_enable = 1'b0;
  check_all_settings();
  check_byte("set_strobe pulses", strobes_before, set_strobe_count);
  send_line("L2");
  expect_silence(40);
  send_line("q#L0");
  expect_response(la_host_pkg::RESPONSE_SUCCESS, 1'b0, 1'b0);
  check_all_settings();
endtask

task automatic overflow_test();
  full_mode = FULL_HIGH;
  repeat (2) @(negedge clk);
  check_bit("rx_overflow", 1'b0, rx_overflow);
  // junk piles up while the parser waits on the held response
  send_line("L0");
  send_line("xxxxxxxxxxxxxxxxxxxx");
  @(negedge clk);
  check_bit("rx_overflow", 1'b1, rx_overflow);
  full_mode = FULL_LOW;
  expect_response(la_host_pkg::RESPONSE_SUCCESS, 1'b0, 1'b0);
  expect_silence(80);
  check_bit("rx_overflow", 1'b1, rx_overflow);
  check_all_settings();
endtask

task automatic run_tests();
  check_all_settings();
  check_bit("rx_overflow", 1'b0, rx_overflow);
  ping_test();
  write_settings_test();
  enable_test();
  reset_opcode_test();
  line_abort_test();
  overflow_test();
endtask

`endif

// File: tb/la_host_link_tb.sv
`timescale 1ns/1ps
`default_nettype none

module la_host_link_tb;

  // bytes in all test lines, line feeds included
  localparam int TEST_BYTES      = 3 + 90 + 22 + 6 + 17 + 24;
  localparam int WATCHDOG_CYCLES = TEST_BYTES * 200;
  localparam int RESPONSE_WAIT   = 200;

  // tx_full drive modes
  localparam int FULL_LOW    = 0;
  localparam int FULL_RANDOM = 1;
  localparam int FULL_HIGH   = 2;

  logic        clk;
  logic        rst;
  logic        rx_strobe;
  logic [7:0]  rx_data;
  logic        tx_full;
  logic        disable_capture;
  logic        tx_strobe;
  logic [7:0]  tx_data;
  logic        rx_overflow;
  logic [31:0] trigger;
  logic [31:0] trigger_mask;
  logic [31:0] trigger_after;
  logic [31:0] trigger_edge;
  logic [31:0] both_edges;
  logic [31:0] repeat_count;
  logic        enable;
  logic        set_strobe;
  logic        la_reset;

  logic [7:0]  tx_q [$];
  logic [7:0]  set_strobe_count;
  logic [7:0]  la_reset_count;
  logic [31:0] model_setting [6];
  logic        model_enable;
  int          full_mode;
  int          error_count;
  integer      seed;
  integer      rnd;

  la_host_link uut (
    .clk             (clk),
    .rst             (rst),
    .rx_strobe       (rx_strobe),
    .rx_data         (rx_data),
    .tx_full         (tx_full),
    .disable_capture (disable_capture),
    .tx_strobe       (tx_strobe),
    .tx_data         (tx_data),
    .rx_overflow     (rx_overflow),
    .trigger         (trigger),
    .trigger_mask    (trigger_mask),
    .trigger_after   (trigger_after),
    .trigger_edge    (trigger_edge),
    .both_edges      (both_edges),
    .repeat_count    (repeat_count),
    .enable          (enable),
    .set_strobe      (set_strobe),
    .la_reset        (la_reset)
  );

  always #10 clk = ~clk;

  // transmit sink
  always @(posedge clk) begin
    if (!rst && tx_strobe) begin
      if (tx_full) begin
        stop_run("a byte was sent while the transmit side was full");
      end else begin
        tx_q.push_back(tx_data);
      end
    end
  end

  // pulse counters for the one-cycle strobes
  always @(posedge clk) begin
    if (rst) begin
      set_strobe_count <= 8'd0;
      la_reset_count   <= 8'd0;
    end else begin
      if (set_strobe) begin
        set_strobe_count <= set_strobe_count + 8'd1;
      end
      if (la_reset) begin
        la_reset_count <= la_reset_count + 8'd1;
      end
    end
  end

  // back-pressure from the transmit side
  always @(negedge clk) begin
    case (full_mode)
      FULL_RANDOM: begin
        rnd     = $random(seed);
        tx_full = rnd[0];
      end
      FULL_HIGH: tx_full = 1'b1;
      default:   tx_full = 1'b0;
    endcase
  end

  task automatic stop_run(input string reason);
    error_count++;
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    if (actual !== expected) begin
      stop_run($sformatf("error at %0t: %s expected %h, got %h",
                         $time, name, expected, actual));
    end
  endtask

  task automatic check_setting(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      stop_run($sformatf("error at %0t: %s expected %h, got %h",
                         $time, name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_run($sformatf("error at %0t: %s expected %b, got %b",
                         $time, name, expected, actual));
    end
  endtask

  `include "la_host_link_tests.svh"

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_run("watchdog timeout, the tests did not finish in time");
  end

  initial begin
    clk             = 1'b0;
    rst             = 1'b1;
    rx_strobe       = 1'b0;
    rx_data         = 8'h00;
    tx_full         = 1'b0;
    disable_capture = 1'b0;
    full_mode       = FULL_LOW;
    error_count     = 0;
    seed            = 32'h0141_30ec;
    model_enable    = 1'b0;
    foreach (model_setting[k]) begin
      model_setting[k] = 32'h0;
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;
    run_tests();
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
